// File: common/spad_cfg_pkg.sv
package spad_cfg_pkg;

  // one word of the scratchpad is 32 bits wide.
  localparam int DATA_W = 32;

  // number of byte lanes in a word, each with its own write enable.
  localparam int BYTES = DATA_W / 8;

  // depth of the block RAM in words.
  localparam int ELS = 256;

  // word address width, taken from the depth.
  localparam int WADDR_W = $clog2(ELS); // 8 bits for 256 words.

  // width of the byte offset inside a word.
  localparam int OFF_W = $clog2(BYTES); // 2 bits for 4 lanes.

  // full byte address as seen on the request port.
  localparam int ADDR_W = WADDR_W + OFF_W;

endpackage

// File: common/spad_op_pkg.sv
package spad_op_pkg;

  // width of the access-size code on the request port.
  localparam int SIZE_W = 2;

  // access sizes of a load or store.
  // the spare code 3 is decoded as a full word by every consumer.
  typedef enum logic [SIZE_W-1:0]
  {
    SZ_BYTE = 2'd0, // one lane.
    SZ_HALF = 2'd1, // two lanes with offset bit 0 ignored.
    SZ_WORD = 2'd2  // all lanes with the offset ignored.
  } size_e;

endpackage

// File: hw/spad_mem/spad_mem_bytemask.sv
module spad_mem_bytemask
(
  input  logic                              clk_i,
  input  logic                              v_i,      // port enable.
  input  logic                              w_i,      // write when set with v_i.
  input  logic [spad_cfg_pkg::WADDR_W-1:0]  addr_i,   // word address.
  input  logic [spad_cfg_pkg::DATA_W-1:0]   data_i,
  input  logic [spad_cfg_pkg::BYTES-1:0]    wmask_i,  // one bit per byte lane.
  output logic [spad_cfg_pkg::DATA_W-1:0]   data_o
);

  // ELS words with a write enable for each byte lane.
  logic [spad_cfg_pkg::DATA_W-1:0] mem [spad_cfg_pkg::ELS];
  logic [spad_cfg_pkg::BYTES-1:0]  lane_we;
  logic [spad_cfg_pkg::DATA_W-1:0] rd_q;

  assign lane_we = {spad_cfg_pkg::BYTES{v_i & w_i}} & wmask_i;

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < spad_cfg_pkg::BYTES; i++)
    begin
      if (lane_we[i])
        mem[addr_i][i*8 +: 8] <= data_i[i*8 +: 8];
    end
  end

  // in no-change mode any byte written in a cycle keeps the old read value.
  always_ff @(posedge clk_i)
  begin
    if (v_i && !(|lane_we))
      rd_q <= mem[addr_i];
  end

  assign data_o = rd_q;

endmodule

// File: hw/spad_store_align.sv
module spad_store_align
(
  input  logic [spad_op_pkg::SIZE_W-1:0]    size_i,
  input  logic [spad_cfg_pkg::OFF_W-1:0]    off_i,        // byte offset in the word.
  input  logic [spad_cfg_pkg::DATA_W-1:0]   wdata_i,      // right-justified store data.
  input  logic                              clr_active_i,
  output logic [spad_cfg_pkg::DATA_W-1:0]   wdata_o,
  output logic [spad_cfg_pkg::BYTES-1:0]    wmask_o
);

  localparam logic [spad_cfg_pkg::BYTES-1:0] ONE_LANE  = spad_cfg_pkg::BYTES'(1);
  localparam logic [spad_cfg_pkg::BYTES-1:0] TWO_LANES = spad_cfg_pkg::BYTES'(3);

  logic [spad_cfg_pkg::OFF_W-1:0] half_base; // offset with bit 0 dropped.

  assign half_base = {off_i[spad_cfg_pkg::OFF_W-1:1], 1'b0};

  always_comb
  begin
    // data is copied into every lane, and the mask picks where it lands.
    case (spad_op_pkg::size_e'(size_i))
      spad_op_pkg::SZ_BYTE:
      begin
        wdata_o = {spad_cfg_pkg::BYTES{wdata_i[7:0]}};
        wmask_o = ONE_LANE << off_i;
      end
      spad_op_pkg::SZ_HALF:
      begin
        wdata_o = {(spad_cfg_pkg::BYTES/2){wdata_i[15:0]}};
        wmask_o = TWO_LANES << half_base;
      end
      default:
      begin
        wdata_o = wdata_i;  // word, and the spare code 3 as well.
        wmask_o = '1;
      end
    endcase
    if (clr_active_i)
    begin
      wdata_o = '0;  // the sweep zeroes a full word each cycle.
      wmask_o = '1;
    end
  end

endmodule

// File: hw/spad_load_extract.sv
module spad_load_extract
(
  input  logic [spad_cfg_pkg::DATA_W-1:0]   rword_i,    // word from the RAM read register.
  input  logic [spad_cfg_pkg::OFF_W-1:0]    off_i,
  input  logic [spad_op_pkg::SIZE_W-1:0]    size_i,
  input  logic                              unsigned_i,
  output logic [spad_cfg_pkg::DATA_W-1:0]   rdata_o
);

  logic [spad_cfg_pkg::OFF_W-1:0]  base;     // aligned lane index.
  logic [spad_cfg_pkg::DATA_W-1:0] shifted;  // selected lanes moved down to bit 0.
  logic                            sign_b;
  logic                            sign_h;

  always_comb
  begin
    // low offset bits below the access size are ignored.
    case (spad_op_pkg::size_e'(size_i))
      spad_op_pkg::SZ_BYTE: base = off_i;
      spad_op_pkg::SZ_HALF: base = {off_i[spad_cfg_pkg::OFF_W-1:1], 1'b0};
      default:              base = '0;
    endcase
  end

  assign shifted = rword_i >> {base, 3'b000};

  // the fill bit is the top loaded bit unless the load is unsigned.
  assign sign_b = ~unsigned_i & shifted[7];
  assign sign_h = ~unsigned_i & shifted[15];

  always_comb
  begin
    case (spad_op_pkg::size_e'(size_i))
      spad_op_pkg::SZ_BYTE:
        rdata_o = {{(spad_cfg_pkg::DATA_W-8){sign_b}}, shifted[7:0]};
      spad_op_pkg::SZ_HALF:
        rdata_o = {{(spad_cfg_pkg::DATA_W-16){sign_h}}, shifted[15:0]};
      default:
        rdata_o = rword_i; // a word comes back untouched.
    endcase
  end

endmodule

// File: hw/spad_ctrl.sv
module spad_ctrl
(
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [spad_cfg_pkg::ADDR_W-1:0]   addr_i,
  input  logic [spad_op_pkg::SIZE_W-1:0]    size_i,
  input  logic                              unsigned_i,
  input  logic                              clear_i,
  output logic                              mem_v_o,
  output logic                              mem_w_o,
  output logic [spad_cfg_pkg::WADDR_W-1:0]  mem_addr_o,
  output logic                              clr_active_o,
  output logic [spad_cfg_pkg::OFF_W-1:0]    ld_off_o,
  output logic [spad_op_pkg::SIZE_W-1:0]    ld_size_o,
  output logic                              ld_unsigned_o,
  output logic                              rvalid_o,
  output logic                              busy_o
);

  localparam logic [spad_cfg_pkg::WADDR_W-1:0] LAST_WORD =
    spad_cfg_pkg::WADDR_W'(spad_cfg_pkg::ELS - 1);

  logic                              busy_q;     // high while the clear sweep runs.
  logic [spad_cfg_pkg::WADDR_W-1:0]  sweep_q;    // word being zeroed this cycle.
  logic                              rvalid_q;
  logic                              clr_go;
  logic                              req_go;
  logic                              ld_go;
  logic [spad_cfg_pkg::OFF_W-1:0]    ld_off_q;
  logic [spad_op_pkg::SIZE_W-1:0]    ld_size_q;
  logic                              ld_unsigned_q;

  // nothing is taken while busy, and a clear beats a request in the same cycle.
  assign clr_go = clear_i & ~busy_q;
  assign req_go = req_i & ~busy_q & ~clear_i;
  assign ld_go  = req_go & ~we_i; // an accepted request without we_i is a load.

  // the sweep owns the RAM port for a full write every cycle it runs.
  assign mem_v_o    = busy_q | req_go;
  assign mem_w_o    = busy_q | (req_go & we_i);
  assign mem_addr_o = busy_q ? sweep_q : addr_i[spad_cfg_pkg::ADDR_W-1:spad_cfg_pkg::OFF_W];

  assign clr_active_o = busy_q; // store path forces zeros and a full mask.

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_q   <= 1'b0;
      sweep_q  <= '0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      if (clr_go)
      begin
        busy_q  <= 1'b1;   // first write lands on the next edge.
        sweep_q <= '0;
      end
      else if (busy_q)
      begin
        sweep_q <= sweep_q + 1'b1;
        if (sweep_q == LAST_WORD)
          busy_q <= 1'b0;  // the last word is written on this edge.
      end
      // the RAM read register loads on the same edge, so the flag lines up with it.
      rvalid_q <= ld_go;
    end
  end

  // load context follows the word into the RAM read register.
  always_ff @(posedge clk_i)
  begin
    if (ld_go)
    begin
      ld_off_q      <= addr_i[spad_cfg_pkg::OFF_W-1:0];
      ld_size_q     <= size_i;
      ld_unsigned_q <= unsigned_i;
    end
  end

  assign ld_off_o      = ld_off_q;
  assign ld_size_o     = ld_size_q;
  assign ld_unsigned_o = ld_unsigned_q;
  assign rvalid_o      = rvalid_q;
  assign busy_o        = busy_q;

endmodule

// File: hw/spad_top.sv
module spad_top
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                req_i,      // request strobe.
  input  logic                                we_i,       // high for a store.
  input  logic [spad_cfg_pkg::ADDR_W-1:0]     addr_i,     // byte address.
  input  logic [spad_op_pkg::SIZE_W-1:0]      size_i,
  input  logic                                unsigned_i, // zero-extend loads.
  input  logic [spad_cfg_pkg::DATA_W-1:0]     wdata_i,
  input  logic                                clear_i,    // clear strobe.
  output logic [spad_cfg_pkg::DATA_W-1:0]     rdata_o,
  output logic                                rvalid_o,
  output logic                                busy_o
);

  logic                               mem_v;
  logic                               mem_w;
  logic [spad_cfg_pkg::WADDR_W-1:0]   mem_addr;
  logic [spad_cfg_pkg::DATA_W-1:0]    mem_wdata;  // lane-aligned store word.
  logic [spad_cfg_pkg::BYTES-1:0]     mem_wmask;
  logic [spad_cfg_pkg::DATA_W-1:0]    mem_rdata;  // read register of the RAM.
  logic                               clr_active;
  logic [spad_cfg_pkg::OFF_W-1:0]     ld_off;     // context of the load leaving the RAM.
  logic [spad_op_pkg::SIZE_W-1:0]     ld_size;
  logic                               ld_unsigned;

  // request acceptance, clear sweep and load context.
  spad_ctrl spad_ctrl_i
  (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .size_i        (size_i),
    .unsigned_i    (unsigned_i),
    .clear_i       (clear_i),
    .mem_v_o       (mem_v),
    .mem_w_o       (mem_w),
    .mem_addr_o    (mem_addr),
    .clr_active_o  (clr_active),
    .ld_off_o      (ld_off),
    .ld_size_o     (ld_size),
    .ld_unsigned_o (ld_unsigned),
    .rvalid_o      (rvalid_o),
    .busy_o        (busy_o)
  );

  // the store path works straight off the request ports.
  spad_store_align spad_store_align_i
  (
    .size_i       (size_i),
    .off_i        (addr_i[spad_cfg_pkg::OFF_W-1:0]),
    .wdata_i      (wdata_i),
    .clr_active_i (clr_active),
    .wdata_o      (mem_wdata),
    .wmask_o      (mem_wmask)
  );

  spad_mem_bytemask spad_mem_bytemask_i
  (
    .clk_i   (clk_i),
    .v_i     (mem_v),
    .w_i     (mem_w),
    .addr_i  (mem_addr),
    .data_i  (mem_wdata),
    .wmask_i (mem_wmask),
    .data_o  (mem_rdata)
  );

  spad_load_extract spad_load_extract_i
  (
    .rword_i    (mem_rdata),
    .off_i      (ld_off),
    .size_i     (ld_size),
    .unsigned_i (ld_unsigned),
    .rdata_o    (rdata_o)
  );

endmodule

// File: bench/spad_tb.sv
module spad_tb;

  localparam int PERIOD  = 100;
  localparam int SEED    = 66889;
  localparam int N_OPS   = 400;  // length of the random mixed phase.
  localparam int LIMIT   = (N_OPS + 3 * spad_cfg_pkg::ELS + 50) * PERIOD;
  localparam int N_BYTES = spad_cfg_pkg::ELS * spad_cfg_pkg::BYTES;

  logic                               clk_i;
  logic                               arst_n_i;
  logic                               req_i;
  logic                               we_i;
  logic [spad_cfg_pkg::ADDR_W-1:0]    addr_i;
  logic [spad_op_pkg::SIZE_W-1:0]     size_i;
  logic                               unsigned_i;
  logic [spad_cfg_pkg::DATA_W-1:0]    wdata_i;
  logic                               clear_i;
  logic [spad_cfg_pkg::DATA_W-1:0]    rdata_o;
  logic                               rvalid_o;
  logic                               busy_o;

  logic [7:0]                         shadow [N_BYTES]; // byte-wide copy of the memory.
  logic [spad_cfg_pkg::DATA_W-1:0]    exp_q [$];        // loads still waiting for rvalid_o.
  logic [spad_cfg_pkg::DATA_W-1:0]    exp_data;         // value due on rdata_o this cycle.
  int                                 busy_cnt;         // sweep cycles left in the model.
  int                                 errors;
  logic                               load_acc;

  spad_top spad_top_i
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .size_i     (size_i),
    .unsigned_i (unsigned_i),
    .wdata_i    (wdata_i),
    .clear_i    (clear_i),
    .rdata_o    (rdata_o),
    .rvalid_o   (rvalid_o),
    .busy_o     (busy_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // a load is taken when no sweep runs and no clear comes with it.
  assign load_acc = req_i & ~we_i & ~clear_i & (busy_cnt == 0);

  always @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      busy_cnt <= 0;
    else if (clear_i && busy_cnt == 0)
      busy_cnt <= spad_cfg_pkg::ELS;  // one word is zeroed per cycle.
    else if (busy_cnt != 0)
      busy_cnt <= busy_cnt - 1;
  end

  // every accepted load gives exactly one rvalid_o cycle, and nothing else does.
  assert property (@(posedge clk_i) disable iff (!arst_n_i) rvalid_o == $past(load_acc))
  else
  begin
    errors++;
    if ($sampled(rvalid_o))
      $display("rvalid_o was high at %0t with no load accepted before it.", $time);
    else
      $display("rvalid_o was missing at %0t after an accepted load.", $time);
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   rvalid_o |-> (rdata_o == exp_data))
  else
  begin
    errors++;
    $display("Fail at %0t: rdata_o expected %h, actual %h",
             $time, $sampled(exp_data), $sampled(rdata_o));
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) busy_o == (busy_cnt != 0))
  else
  begin
    errors++;
    $display("Fail at %0t: busy_o expected %b, actual %b",
             $time, $sampled(busy_cnt) != 0, $sampled(busy_o));
  end

  // lanes touched by an access, and the first of them after alignment.
  function automatic int lane_count(input int size);
    if (size == int'(spad_op_pkg::SZ_BYTE))
      return 1;
    if (size == int'(spad_op_pkg::SZ_HALF))
      return 2;
    return spad_cfg_pkg::BYTES; // word and the spare code.
  endfunction

  function automatic int lane_base(input int addr, input int size);
    return addr - (addr % lane_count(size));
  endfunction

  function automatic logic [spad_cfg_pkg::DATA_W-1:0] expect_load(input int addr,
                                                                  input int size,
                                                                  input logic uns);
    int                              n;
    int                              base;
    logic [spad_cfg_pkg::DATA_W-1:0] val;
    n    = lane_count(size);
    base = lane_base(addr, size);
    val  = '0;
    for (int i = 0; i < n; i++)
      val[i*8 +: 8] = shadow[base + i];  // lanes come back right-justified.
    // fill with the top loaded bit for signed short loads.
    if (n < spad_cfg_pkg::BYTES && !uns && val[n*8-1])
    begin
      for (int i = n * 8; i < spad_cfg_pkg::DATA_W; i++)
        val[i] = 1'b1;
    end
    return val;
  endfunction

  // each step waits for the falling edge, retires a finished load and releases the strobes.
  task automatic tick();
    @(negedge clk_i);
    if (rvalid_o)
    begin
      assert (exp_q.size() != 0)
      else
      begin
        errors++;
        $display("rvalid_o high at %0t with no load outstanding.", $time);
      end
      if (exp_q.size() != 0)
        exp_data = exp_q.pop_front();
    end
    req_i   = 1'b0;
    clear_i = 1'b0;
  endtask

  task automatic drive_req(input logic we, input int addr, input int size, input logic uns,
                           input logic [spad_cfg_pkg::DATA_W-1:0] data);
    req_i      = 1'b1;
    we_i       = we;
    addr_i     = spad_cfg_pkg::ADDR_W'(addr);
    size_i     = spad_op_pkg::SIZE_W'(size);
    unsigned_i = uns;
    wdata_i    = data;
  endtask

  task automatic issue_store(input int addr, input int size,
                             input logic [spad_cfg_pkg::DATA_W-1:0] data);
    int base;
    tick();
    drive_req(1'b1, addr, size, 1'b0, data);
    base = lane_base(addr, size);
    if (busy_cnt == 0)
    begin
      for (int i = 0; i < lane_count(size); i++)
        shadow[base + i] = data[i*8 +: 8];  // low data bytes go to the aligned lanes.
    end
  endtask

  task automatic issue_load(input int addr, input int size, input logic uns);
    tick();
    drive_req(1'b0, addr, size, uns, $urandom());
    if (busy_cnt == 0)
      exp_q.push_back(expect_load(addr, size, uns));
  endtask

  task automatic issue_clear();
    tick();
    clear_i = 1'b1;
    if (busy_cnt == 0)
    begin
      for (int i = 0; i < N_BYTES; i++)
        shadow[i] = 8'h00;
    end
  endtask

  task automatic wait_idle();
    tick();
    while (busy_o)
      tick();
  endtask

  initial
  begin
    #(LIMIT);
    $display("watchdog expired at %0t before the tests finished.", $time);
    $display("Errors found");
    $finish;
  end

  initial
  begin
    void'($urandom(SEED));
    errors     = 0;
    exp_data   = '0;
    arst_n_i   = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    size_i     = '0;
    unsigned_i = 1'b0;
    wdata_i    = '0;
    clear_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    assert (!busy_o && !rvalid_o)
    else
    begin
      errors++;
      $display("busy_o or rvalid_o was high right after reset.");
    end
    issue_clear();  // memory holds no known data before this.
    wait_idle();
    for (int i = 0; i < 8; i++)
      issue_load($urandom_range(0, N_BYTES - 1), 2, 1'b0);
    // mixed-size stores into a small window, read back as full words.
    for (int i = 0; i < 24; i++)
      issue_store($urandom_range(0, 63), $urandom_range(0, 2), $urandom());
    for (int i = 0; i < 16; i++)
      issue_load(i * 4 + $urandom_range(0, 3), 2, 1'b0);
    // words with set top bits in several lanes for the extension checks.
    issue_store(80, 2, 32'h80ff_7f01);
    issue_store(84, 2, 32'h7fff_8000);
    for (int a = 80; a < 88; a++)
    begin
      issue_load(a, 0, 1'b0);
      issue_load(a, 0, 1'b1);
      issue_load(a, 1, 1'b0);
      issue_load(a, 1, 1'b1);
    end
    issue_store(257, 1, $urandom());  // odd halfword address.
    issue_store(262, 2, $urandom());  // word address off by two.
    issue_load(256, 2, 1'b0);
    issue_load(260, 2, 1'b0);
    // the clear beats a load in the same cycle, and all traffic while busy is dropped.
    issue_clear();
    drive_req(1'b0, 0, 2, 1'b0, '0);
    for (int i = 0; i < 12; i++)
    begin
      issue_store($urandom_range(0, 63), $urandom_range(0, 3), $urandom());
      issue_load($urandom_range(0, 63), $urandom_range(0, 3), 1'(($urandom() & 1)));
    end
    issue_clear();
    wait_idle();
    for (int i = 0; i < 16; i++)
      issue_load(i * 4, 2, 1'b0);
    // random loads and stores, often back to back, over a small address range.
    for (int i = 0; i < N_OPS; i++)
    begin
      case ($urandom_range(0, 9))
        0, 1, 2, 3, 4:
          issue_load($urandom_range(0, 127), $urandom_range(0, 3), 1'(($urandom() & 1)));
        5, 6, 7, 8:
          issue_store($urandom_range(0, 127), $urandom_range(0, 3), $urandom());
        default:
          tick();
      endcase
    end
    repeat (3) tick();
    assert (exp_q.size() == 0)
    else
    begin
      errors++;
      $display("%0d loads never produced rvalid_o.", exp_q.size());
    end
    $display("checks failed: %0d", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: spad_top.f
common/spad_cfg_pkg.sv
common/spad_op_pkg.sv
hw/spad_mem/spad_mem_bytemask.sv
hw/spad_store_align.sv
hw/spad_load_extract.sv
hw/spad_ctrl.sv
hw/spad_top.sv
bench/spad_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the scratchpad testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
  --top-module spad_tb \
  -f spad_top.f \
  -o spad_sim

./obj_dir/spad_sim > sim.log
cat sim.log

if grep -q "^No errors$" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
